//--- logic/armDpPkg.sv
package armDpPkg;

  // Datapath word width and architectural register count
  localparam int DataWidth = 32;
  localparam int RegCount  = 16;

  // Register index wide enough for R0 to R15
  typedef logic [$clog2(RegCount)-1:0] regIdxT;

  // Data-processing opcodes in ARM bit order, instr[24:21]
  typedef enum logic [3:0] {
    OpAnd = 4'b0000,
    OpEor = 4'b0001,
    OpSub = 4'b0010,
    OpRsb = 4'b0011,
    OpAdd = 4'b0100,
    OpAdc = 4'b0101,
    OpSbc = 4'b0110,
    OpRsc = 4'b0111,
    OpTst = 4'b1000,
    OpTeq = 4'b1001,
    OpCmp = 4'b1010,
    OpCmn = 4'b1011,
    OpOrr = 4'b1100,
    OpMov = 4'b1101,
    OpBic = 4'b1110,
    OpMvn = 4'b1111
  } dpOpT;

  // Shift kinds, instr[6:5]
  typedef enum logic [1:0] {
    ShLsl = 2'b00,
    ShLsr = 2'b01,
    ShAsr = 2'b10,
    ShRor = 2'b11
  } shiftTypeT;

  // Condition flags, in CPSR order from bit 31 down
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Immediate form of instr[11:0]
  typedef struct packed {
    logic [3:0] rotate;
    logic [7:0] imm8;
  } immOperandT;

  // Register form of instr[11:0]; regShift set means shift by Rs
  typedef struct packed {
    logic [4:0] shiftAmt;
    shiftTypeT  shiftType;
    logic       regShift;
    regIdxT     rm;
  } regOperandT;

  // Same 12 bits, read one way or the other depending on instr[25]
  typedef union packed {
    immOperandT immForm;
    regOperandT regForm;
  } shifterOperandT;

endpackage

//--- logic/dpDecoder.sv
module dpDecoder (
  input  logic [armDpPkg::DataWidth-1:0] instr,
  input  logic                           instrValid,
  output armDpPkg::dpOpT                 aluOp,
  output armDpPkg::regIdxT               rn,
  output armDpPkg::regIdxT               rm,
  output armDpPkg::regIdxT               rd,
  output logic                           immSel,
  output armDpPkg::shiftTypeT            shiftType,
  output logic [4:0]                     shiftAmt,
  output logic [3:0]                     rotImm,
  output logic [7:0]                     imm8,
  output logic                           setFlags,
  output logic                           regWrite,
  output logic                           useRn
);
  import armDpPkg::*;

  shifterOperandT operand;
  logic           compareOp;
  logic           moveOp;

  // Fixed instruction fields
  assign operand = instr[11:0];
  assign aluOp   = dpOpT'(instr[24:21]);
  assign rn      = instr[19:16];
  assign rd      = instr[15:12];
  assign immSel  = instr[25];

  // Pick the operand view from the I bit, unused fields held at zero
  always_comb begin
    rotImm    = '0;
    imm8      = '0;
    shiftAmt  = '0;
    shiftType = ShLsl;
    rm        = '0;
    if (immSel) begin
      rotImm = operand.immForm.rotate;
      imm8   = operand.immForm.imm8;
    end else begin
      shiftAmt  = operand.regForm.shiftAmt;
      shiftType = operand.regForm.shiftType;
      rm        = operand.regForm.rm;
    end
  end

  // TST, TEQ, CMP and CMN share opcode prefix 2'b10
  assign compareOp = (instr[24:23] == 2'b10);
  // MOV and MVN ignore Rn
  assign moveOp    = (aluOp == OpMov) || (aluOp == OpMvn);

  // Enables are dead when no instruction is presented
  assign regWrite = instrValid && !compareOp;
  assign setFlags = instrValid && instr[20];
  assign useRn    = !moveOp;

  // Only immediate shift amounts are executed by this core
  always_comb begin
    if (instrValid && !immSel) begin
      assert final (operand.regForm.regShift == 1'b0)
        else $error("register-specified shift amount in instr %h", instr);
    end
  end

endmodule

//--- logic/regFile.sv
module regFile (
  input  logic                           clk,
  input  logic                           arstN,
  input  armDpPkg::regIdxT               ra1,
  input  armDpPkg::regIdxT               ra2,
  output logic [armDpPkg::DataWidth-1:0] rd1,
  output logic [armDpPkg::DataWidth-1:0] rd2,
  input  logic                           we,
  input  armDpPkg::regIdxT               wa,
  input  logic [armDpPkg::DataWidth-1:0] wd
);
  import armDpPkg::*;

  logic [DataWidth-1:0] regs [RegCount];

  // All registers start at zero
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < RegCount; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

  // Write-through so decode sees the value landing this cycle
  assign rd1 = (we && (wa == ra1)) ? wd : regs[ra1];
  assign rd2 = (we && (wa == ra2)) ? wd : regs[ra2];

endmodule

//--- logic/barrelShifter.sv
module barrelShifter (
  input  logic [armDpPkg::DataWidth-1:0] value,
  input  logic                           immSel,
  input  logic [7:0]                     imm8,
  input  logic [3:0]                     rotImm,
  input  armDpPkg::shiftTypeT            shiftType,
  input  logic [4:0]                     shiftAmt,
  input  logic                           carryIn,
  output logic [armDpPkg::DataWidth-1:0] shifted,
  output logic                           shiftCarry
);
  import armDpPkg::*;

  logic [DataWidth-1:0]   immWord;
  logic [4:0]             immRot;
  logic [2*DataWidth-1:0] immDouble;
  logic [2*DataWidth-1:0] rorDouble;
  logic [DataWidth:0]     lslExt;
  logic [DataWidth:0]     lsrExt;
  logic [DataWidth:0]     asrExt;

  // Immediate rotates right by twice the 4-bit field
  assign immWord   = {{(DataWidth-8){1'b0}}, imm8};
  assign immRot    = {rotImm, 1'b0};
  assign immDouble = {immWord, immWord} >> immRot;

  // Rotation via a doubled word, low half is the result
  assign rorDouble = {value, value} >> shiftAmt;
  // One extra bit catches the last bit shifted out
  assign lslExt    = {1'b0, value} << shiftAmt;
  assign lsrExt    = {value, 1'b0} >> shiftAmt;
  assign asrExt    = $signed({value, 1'b0}) >>> shiftAmt;

  always_comb begin
    shifted    = value;
    shiftCarry = carryIn;
    if (immSel) begin
      shifted    = immDouble[DataWidth-1:0];
      // Unrotated immediates leave C alone
      shiftCarry = (rotImm == 4'd0) ? carryIn : immDouble[DataWidth-1];
    end else begin
      unique case (shiftType)
        ShLsl: begin
          // LSL #0 is a plain move with C untouched
          if (shiftAmt != 5'd0) begin
            shifted    = lslExt[DataWidth-1:0];
            shiftCarry = lslExt[DataWidth];
          end
        end
        ShLsr: begin
          // Amount 0 encodes LSR #32
          shifted    = (shiftAmt == 5'd0) ? '0 : lsrExt[DataWidth:1];
          shiftCarry = (shiftAmt == 5'd0) ? value[DataWidth-1] : lsrExt[0];
        end
        ShAsr: begin
          // Amount 0 encodes ASR #32, all sign bits
          shifted    = (shiftAmt == 5'd0) ? {DataWidth{value[DataWidth-1]}}
                                          : asrExt[DataWidth:1];
          shiftCarry = (shiftAmt == 5'd0) ? value[DataWidth-1] : asrExt[0];
        end
        ShRor: begin
          // Amount 0 encodes RRX through the carry flag
          shifted    = (shiftAmt == 5'd0) ? {carryIn, value[DataWidth-1:1]}
                                          : rorDouble[DataWidth-1:0];
          shiftCarry = (shiftAmt == 5'd0) ? value[0] : rorDouble[DataWidth-1];
        end
      endcase
    end
  end

endmodule

//--- logic/alu.sv
module alu (
  input  logic [armDpPkg::DataWidth-1:0] srcA,
  input  logic [armDpPkg::DataWidth-1:0] srcB,
  input  armDpPkg::dpOpT                 aluOp,
  input  logic                           carryIn,
  input  logic                           oldV,
  input  logic                           shiftCarry,
  output logic [armDpPkg::DataWidth-1:0] result,
  output armDpPkg::flagsT                aluFlags
);
  import armDpPkg::*;

  logic [DataWidth-1:0] addA;
  logic [DataWidth-1:0] addB;
  logic                 addCin;
  logic                 arith;
  logic [DataWidth-1:0] logicRes;
  logic [DataWidth:0]   sum;

  // Adder input steering and the logical result
  always_comb begin
    addA     = srcA;
    addB     = srcB;
    addCin   = 1'b0;
    arith    = 1'b1;
    logicRes = '0;
    unique case (aluOp)
      OpSub, OpCmp: begin
        addB   = ~srcB;
        addCin = 1'b1;
      end
      OpRsb: begin
        addA   = ~srcA;
        addCin = 1'b1;
      end
      OpAdd, OpCmn: addCin = 1'b0;
      OpAdc:        addCin = carryIn;
      OpSbc: begin
        addB   = ~srcB;
        addCin = carryIn;
      end
      OpRsc: begin
        addA   = ~srcA;
        addCin = carryIn;
      end
      // Logical group below
      OpAnd, OpTst: begin
        arith    = 1'b0;
        logicRes = srcA & srcB;
      end
      OpEor, OpTeq: begin
        arith    = 1'b0;
        logicRes = srcA ^ srcB;
      end
      OpOrr: begin
        arith    = 1'b0;
        logicRes = srcA | srcB;
      end
      OpMov: begin
        arith    = 1'b0;
        logicRes = srcB;
      end
      OpBic: begin
        arith    = 1'b0;
        logicRes = srcA & ~srcB;
      end
      OpMvn: begin
        arith    = 1'b0;
        logicRes = ~srcB;
      end
    endcase
  end

  // Single shared adder for every arithmetic opcode
  assign sum    = {1'b0, addA} + {1'b0, addB} + addCin;
  assign result = arith ? sum[DataWidth-1:0] : logicRes;

  // NZ from the result, C and V from adder or shifter
  assign aluFlags.n = result[DataWidth-1];
  assign aluFlags.z = (result == '0);
  assign aluFlags.c = arith ? sum[DataWidth] : shiftCarry;
  assign aluFlags.v = arith ? ((addA[DataWidth-1] == addB[DataWidth-1]) &&
                               (sum[DataWidth-1] != addA[DataWidth-1]))
                            : oldV;

endmodule

//--- logic/dpDatapath.sv
module dpDatapath (
  input  logic                           clk,
  input  logic                           arstN,
  input  armDpPkg::dpOpT                 aluOp,
  input  armDpPkg::regIdxT               rn,
  input  armDpPkg::regIdxT               rm,
  input  armDpPkg::regIdxT               rd,
  input  logic                           immSel,
  input  armDpPkg::shiftTypeT            shiftType,
  input  logic [4:0]                     shiftAmt,
  input  logic [3:0]                     rotImm,
  input  logic [7:0]                     imm8,
  input  logic                           setFlags,
  input  logic                           regWrite,
  input  logic                           useRn,
  output logic                           wbValid,
  output armDpPkg::regIdxT               wbRd,
  output logic [armDpPkg::DataWidth-1:0] wbData,
  output armDpPkg::flagsT                flags
);
  import armDpPkg::*;

  // Decode stage read data
  logic [DataWidth-1:0] rd1;
  logic [DataWidth-1:0] rd2;
  // Execute stage registers
  logic                 exRegWrite;
  logic                 exSetFlags;
  dpOpT                 exAluOp;
  regIdxT               exRn;
  regIdxT               exRm;
  regIdxT               exRd;
  logic                 exImmSel;
  shiftTypeT            exShiftType;
  logic [4:0]           exShiftAmt;
  logic [3:0]           exRotImm;
  logic [7:0]           exImm8;
  logic                 exUseRn;
  logic [DataWidth-1:0] exRd1;
  logic [DataWidth-1:0] exRd2;
  // Execute stage combinational
  logic                 fwdA;
  logic                 fwdB;
  logic [DataWidth-1:0] srcA;
  logic [DataWidth-1:0] opB;
  logic [DataWidth-1:0] shiftedB;
  logic                 shiftCarry;
  logic [DataWidth-1:0] aluResult;
  flagsT                aluFlags;

  // ==================================================
  // Decode
  // ==================================================
  // Single write port is driven straight from the writeback register
  regFile i_regFile (
    .clk   (clk),
    .arstN (arstN),
    .ra1   (rn),
    .ra2   (rm),
    .rd1   (rd1),
    .rd2   (rd2),
    .we    (wbValid),
    .wa    (wbRd),
    .wd    (wbData)
  );

  // Enables reset, bubbles carry them low
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exRegWrite <= 1'b0;
      exSetFlags <= 1'b0;
    end else begin
      exRegWrite <= regWrite;
      exSetFlags <= setFlags;
    end
  end

  always_ff @(posedge clk) begin
    exAluOp     <= aluOp;
    exRn        <= rn;
    exRm        <= rm;
    exRd        <= rd;
    exImmSel    <= immSel;
    exShiftType <= shiftType;
    exShiftAmt  <= shiftAmt;
    exRotImm    <= rotImm;
    exImm8      <= imm8;
    exUseRn     <= useRn;
    exRd1       <= rd1;
    exRd2       <= rd2;
  end

  // ==================================================
  // Execute
  // ==================================================
  // Previous instruction's result bypasses the register file
  assign fwdA = wbValid && (wbRd == exRn);
  assign fwdB = wbValid && (wbRd == exRm);
  assign srcA = !exUseRn ? '0 : (fwdA ? wbData : exRd1);
  assign opB  = fwdB ? wbData : exRd2;

  barrelShifter i_barrelShifter (
    .value      (opB),
    .immSel     (exImmSel),
    .imm8       (exImm8),
    .rotImm     (exRotImm),
    .shiftType  (exShiftType),
    .shiftAmt   (exShiftAmt),
    .carryIn    (flags.c),
    .shifted    (shiftedB),
    .shiftCarry (shiftCarry)
  );

  // Carry and old V come from the live flags register
  alu i_alu (
    .srcA       (srcA),
    .srcB       (shiftedB),
    .aluOp      (exAluOp),
    .carryIn    (flags.c),
    .oldV       (flags.v),
    .shiftCarry (shiftCarry),
    .result     (aluResult),
    .aluFlags   (aluFlags)
  );

  // NZCV register, visible one cycle after execute
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else if (exSetFlags) begin
      flags <= aluFlags;
    end
  end

  // ==================================================
  // Writeback
  // ==================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbValid <= 1'b0;
    end else begin
      wbValid <= exRegWrite;
    end
  end

  // Payload holds across bubbles
  always_ff @(posedge clk) begin
    if (exRegWrite) begin
      wbRd   <= exRd;
      wbData <= aluResult;
    end
  end

  // Writeback qualifier must be a clean 0 or 1 once out of reset
  assert property (@(posedge clk) disable iff (!arstN) !$isunknown(wbValid))
    else $error("wbValid is unknown");

  // Flags move only two cycles behind a decoded S-bit instruction
  assert property (@(posedge clk) disable iff (!arstN)
                   (flags != $past(flags)) |-> $past(setFlags, 2))
    else $error("flags changed without an executing S-bit instruction");

endmodule

//--- logic/dpCore.sv
module dpCore (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic [armDpPkg::DataWidth-1:0] instr,
  input  logic                           instrValid,
  output logic                           wbValid,
  output armDpPkg::regIdxT               wbRd,
  output logic [armDpPkg::DataWidth-1:0] wbData,
  output armDpPkg::flagsT                flags
);
  import armDpPkg::*;

  // Decoded controls, combinational in decode
  dpOpT       aluOp;
  regIdxT     rn;
  regIdxT     rm;
  regIdxT     rd;
  logic       immSel;
  shiftTypeT  shiftType;
  logic [4:0] shiftAmt;
  logic [3:0] rotImm;
  logic [7:0] imm8;
  logic       setFlags;
  logic       regWrite;
  logic       useRn;

  dpDecoder i_dpDecoder (
    .instr      (instr),
    .instrValid (instrValid),
    .aluOp      (aluOp),
    .rn         (rn),
    .rm         (rm),
    .rd         (rd),
    .immSel     (immSel),
    .shiftType  (shiftType),
    .shiftAmt   (shiftAmt),
    .rotImm     (rotImm),
    .imm8       (imm8),
    .setFlags   (setFlags),
    .regWrite   (regWrite),
    .useRn      (useRn)
  );

  // Register file, execute and writeback all live in the datapath
  dpDatapath i_dpDatapath (
    .clk       (clk),
    .arstN     (arstN),
    .aluOp     (aluOp),
    .rn        (rn),
    .rm        (rm),
    .rd        (rd),
    .immSel    (immSel),
    .shiftType (shiftType),
    .shiftAmt  (shiftAmt),
    .rotImm    (rotImm),
    .imm8      (imm8),
    .setFlags  (setFlags),
    .regWrite  (regWrite),
    .useRn     (useRn),
    .wbValid   (wbValid),
    .wbRd      (wbRd),
    .wbData    (wbData),
    .flags     (flags)
  );

endmodule

//--- verification/dpCoreTb.sv
module dpCoreTb;
  import armDpPkg::*;

  logic                 clk;
  logic                 arstN;
  logic [DataWidth-1:0] instr;
  logic                 instrValid;
  logic                 wbValid;
  regIdxT               wbRd;
  logic [DataWidth-1:0] wbData;
  flagsT                flags;

  // Stimulus table as read from the data file
  logic [DataWidth-1:0] stimInstr  [$];
  logic                 stimWrite  [$];
  regIdxT               stimRd     [$];
  logic [DataWidth-1:0] stimResult [$];
  flagsT                stimFlags  [$];
  logic                 stimLoaded;
  // Expected results waiting for the pipeline
  regIdxT               expRdQ     [$];
  logic [DataWidth-1:0] expDataQ   [$];
  flagsT                expFlagsQ  [$];
  int unsigned          lcgState;

  dpCore i_dpCore (
    .clk        (clk),
    .arstN      (arstN),
    .instr      (instr),
    .instrValid (instrValid),
    .wbValid    (wbValid),
    .wbRd       (wbRd),
    .wbData     (wbData),
    .flags      (flags)
  );

  // ==================================================
  // Helpers
  // ==================================================
  // Idle gap source, classic 32-bit LCG
  function automatic int unsigned nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;
  endfunction

  task automatic stopOnError(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic checkRd(input regIdxT expected, input regIdxT actual);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t wbRd expected %0d actual %0d", $time, expected, actual);
      stopOnError("writeback register index mismatch");
    end
  endtask

  task automatic checkWord(input logic [DataWidth-1:0] expected,
                           input logic [DataWidth-1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t wbData expected %h actual %h", $time, expected, actual);
      stopOnError("writeback data mismatch");
    end
  endtask

  task automatic checkFlags(input flagsT expected, input flagsT actual);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t flags expected %b actual %b", $time, expected, actual);
      stopOnError("NZCV mismatch");
    end
  endtask

  // ==================================================
  // Clock, reset and stimulus
  // ==================================================
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  initial begin : driver
    int          fd;
    int          fields;
    int unsigned idle;
    string       textLine;
    logic [31:0] fInstr;
    logic [31:0] fWrite;
    logic [31:0] fRd;
    logic [31:0] fResult;
    logic [31:0] fFlags;
    arstN      = 1'b0;
    instr      = '0;
    instrValid = 1'b0;
    stimLoaded = 1'b0;
    lcgState   = 37511;
    fd = $fopen("verification/dpStimulus.txt", "r");
    if (fd == 0) begin
      stopOnError("could not open verification/dpStimulus.txt");
    end
    while ($fgets(textLine, fd) != 0) begin
      // Comment and blank lines carry no instruction
      if (textLine.len() < 8 || textLine[0] == "#") begin
        continue;
      end
      fields = $sscanf(textLine, "%h %h %h %h %h", fInstr, fWrite, fRd, fResult, fFlags);
      if (fields != 5) begin
        stopOnError("malformed line in the stimulus file");
      end
      stimInstr.push_back(fInstr);
      stimWrite.push_back(fWrite[0]);
      stimRd.push_back(regIdxT'(fRd));
      stimResult.push_back(fResult);
      stimFlags.push_back(flagsT'(fFlags[3:0]));
    end
    $fclose(fd);
    stimLoaded = 1'b1;

    // Reset held for 16 cycles, released on a falling edge
    repeat (16) @(negedge clk);
    arstN = 1'b1;

    foreach (stimInstr[i]) begin
      idle = nextRandom() % 3;
      repeat (idle) begin
        instr      = '0;
        instrValid = 1'b0;
        @(negedge clk);
      end
      instr      = stimInstr[i];
      instrValid = 1'b1;
      // Compares leave no writeback behind
      if (stimWrite[i]) begin
        expRdQ.push_back(stimRd[i]);
        expDataQ.push_back(stimResult[i]);
      end
      expFlagsQ.push_back(stimFlags[i]);
      @(negedge clk);
    end
    instr      = '0;
    instrValid = 1'b0;

    while (expRdQ.size() != 0 || expFlagsQ.size() != 0) begin
      @(negedge clk);
    end
    // A few more cycles to catch stray writebacks
    repeat (4) @(negedge clk);
    $display("TESTS PASSED");
    $finish;
  end

  // ==================================================
  // Result monitor
  // ==================================================
  // Writeback and flags are both stable at the falling edge after N+1
  initial begin : monitor
    logic inExecute;
    logic flagsDue;
    inExecute = 1'b0;
    flagsDue  = 1'b0;
    @(posedge arstN);
    forever begin
      @(posedge clk);
      flagsDue  = inExecute;
      inExecute = instrValid;
      @(negedge clk);
      if (wbValid) begin
        if (expRdQ.size() == 0) begin
          stopOnError("wbValid went high with no writeback expected");
        end
        checkRd(expRdQ.pop_front(), wbRd);
        checkWord(expDataQ.pop_front(), wbData);
      end
      if (flagsDue) begin
        checkFlags(expFlagsQ.pop_front(), flags);
      end
    end
  end

  // Worst case is three cycles per line, five leaves margin
  initial begin : watchdog
    wait (stimLoaded);
    repeat (stimInstr.size() * 5 + 16 + 20) @(posedge clk);
    $display("Timeout: %0d writebacks and %0d flag updates were missing",
             expRdQ.size(), expFlagsQ.size());
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- verification/dpStimulus.txt
# Columns, all hex: instruction, write flag, expected rd, expected result, expected NZCV
# NZCV is the flags value once the instruction has executed
E0821003 1 1 00000000 0
E3A020FF 1 2 000000FF 0
E3A03FFF 1 3 000003FC 0
E3E0443F 1 4 C0FFFFFF 0
E3825C0F 1 5 00000FFF 0
E0946003 1 6 C10003FB 8
E0947004 1 7 81FFFFFE A
E0B78007 1 8 03FFFFFD 3
E0529003 1 9 FFFFFD03 8
E0D3A002 1 A 000002FC 2
E27AB000 1 B FFFFFD04 8
E2F2CC01 1 C 00000000 6
E257D43F 1 D 42FFFFFE 3
E0BDE00D 1 E 85FFFFFD 9
E1520002 0 0 00000000 6
E174000E 0 0 00000000 3
E3150A01 0 0 00000000 5
E1340084 0 0 00000000 3
E1B01224 1 1 0C0FFFFF 3
E1B02044 1 2 FFFFFFFF B
E1B03021 1 3 00000000 5
E1B05062 1 5 7FFFFFFF 3
E1B06461 1 6 FF0C0FFF B
E1B07005 1 7 7FFFFFFF 3
E0168207 1 8 FF0C0FF0 B
E238943F 1 9 C00C0FF0 9
E1C9AA22 1 A C00C0000 9
E08AB00A 1 B 80180000 9
E04BC00A 1 C C00C0000 9
E1A00FEC 1 0 80180001 9

//--- dpCore.f
logic/armDpPkg.sv
logic/dpDecoder.sv
logic/regFile.sv
logic/barrelShifter.sv
logic/alu.sv
logic/dpDatapath.sv
logic/dpCore.sv
verification/dpCoreTb.sv

//--- Bender.yml
package:
  name: dpCore

sources:
  - logic/armDpPkg.sv
  - logic/dpDecoder.sv
  - logic/regFile.sv
  - logic/barrelShifter.sv
  - logic/alu.sv
  - logic/dpDatapath.sv
  - logic/dpCore.sv
  - target: test
    files:
      - verification/dpCoreTb.sv
